// File: core_pkg.sv
/*
 * Shared definitions of the radio control core
 *   Wishbone and settings widths, settings addresses
 *   readback map and reset values
 *   packed structs for bus, settings words, status and board control
 */
`default_nettype none

package core_pkg;

   //////////////////////////////
   // Widths
   localparam int WB_DW           = 32;
   localparam int WB_AW           = 16;
   localparam int WB_SW           = 4;
   localparam int SET_AW          = 8;
   localparam int RB_AW           = 4;
   localparam int RB_SEL_BIT      = 10;
   localparam int FIFO_DEPTH_LOG2 = 2;

   //////////////////////////////
   // Settings addresses
   localparam logic [SET_AW-1:0] SR_MISC    = 8'd0;
   localparam logic [SET_AW-1:0] SR_CLK     = SR_MISC + 8'd0;
   localparam logic [SET_AW-1:0] SR_SER     = SR_MISC + 8'd1;
   localparam logic [SET_AW-1:0] SR_ADC     = SR_MISC + 8'd2;
   localparam logic [SET_AW-1:0] SR_LED_SW  = SR_MISC + 8'd3;
   localparam logic [SET_AW-1:0] SR_PHY     = SR_MISC + 8'd4;
   localparam logic [SET_AW-1:0] SR_LED_SRC = SR_MISC + 8'd6;

   localparam logic [7:0] LED_SRC_AT_RESET = 8'b0001_1110;

   //////////////////////////////
   // Readback window
   // Major in upper half, minor in lower half
   localparam logic [WB_DW-1:0] COMPAT_NUM = {16'd10, 16'd0};
   localparam logic [WB_DW-1:0] RB_FILL    = '1;
   localparam logic [RB_AW-1:0] RB_COMPAT  = 4'd0;
   localparam logic [RB_AW-1:0] RB_LEDS    = 4'd1;
   localparam logic [RB_AW-1:0] RB_BOARD   = 4'd2;
   localparam logic [RB_AW-1:0] RB_STATUS  = 4'd3;

   typedef struct packed {
      logic [SET_AW-1:0] addr;
      logic [WB_DW-1:0]  data;
   } set_word_t;

   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [WB_AW-1:0] adr;
      logic [WB_SW-1:0] sel;
      logic [WB_DW-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic             ack;
      logic [WB_DW-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic run_tx;
      logic run_rx;
      logic clk_status;
      logic serdes_link_up;
      logic good_sync;
   } hw_status_t;

   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset_n;
   } board_ctl_t;

   typedef struct packed {
      logic [7:0] leds;
      board_ctl_t ctl;
      hw_status_t status;
   } rb_words_t;

endpackage

`default_nettype wire

// File: settings_fifo.sv
/*
 * Show-ahead FIFO of settings words
 *   circular buffer with read and write pointers and an occupancy count
 *   head word is visible without latency
 */
`timescale 1ns/100ps
`default_nettype none

module settings_fifo #(
   parameter int DEPTH_LOG2 = 2
) (
   input  wire                    dsp_clk,
   input  wire                    por_rst,
   input  wire                    push_i,
   input  core_pkg::set_word_t    push_word_i,
   input  wire                    pop_i,
   output core_pkg::set_word_t    head_o,
   output logic                   full_o,
   output logic                   empty_o
);

   import core_pkg::*;

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   set_word_t             mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  do_push;
   logic                  do_pop;

   assign full_o  = (count == (DEPTH_LOG2+1)'(DEPTH));
   assign empty_o = (count == '0);

   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   assign head_o = mem[rd_ptr];

   //////////////////////////////
   // Storage
   always_ff @(posedge dsp_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_word_i;
      end
   end

   //////////////////////////////
   // Pointers and count
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves the count alone
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Producer must respect full
   no_push_when_full: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      push_i |-> !full_o
   ) else $error("push into a full settings FIFO");

   // Consumer must respect empty
   no_pop_when_empty: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      pop_i |-> !empty_o
   ) else $error("pop from an empty settings FIFO");

endmodule

`default_nettype wire

// File: settings_wb_slave.sv
/*
 * Wishbone classic slave for the settings bus
 *   writes below the readback region become settings words
 *   reads are held until every queued setting has been applied
 */
`timescale 1ns/100ps
`default_nettype none

module settings_wb_slave (
   input  wire                    dsp_clk,
   input  wire                    por_rst,
   input  core_pkg::wb_req_t      wb_req_i,
   output core_pkg::wb_rsp_t      wb_rsp_o,
   input  wire                    fifo_full_i,
   input  wire                    fifo_empty_i,
   output logic                   push_o,
   output core_pkg::set_word_t    push_word_o,
   input  core_pkg::rb_words_t    rb_words_i
);

   import core_pkg::*;

   logic             req_vld;
   logic             rb_region;
   logic             ack_d;
   logic             ack_q;
   logic [WB_DW-1:0] rb_word;
   logic [WB_DW-1:0] rd_dat_q;
   logic [RB_AW-1:0] rb_idx;

   assign req_vld   = wb_req_i.cyc & wb_req_i.stb;
   assign rb_region = wb_req_i.adr[RB_SEL_BIT];
   assign rb_idx    = wb_req_i.adr[RB_AW+1:2];

   //////////////////////////////
   // Ack decision
   // Writes wait for room, reads wait for the queue to drain
   always_comb begin
      ack_d = 1'b0;
      if (req_vld && !ack_q) begin
         if (!wb_req_i.we)
            ack_d = fifo_empty_i;
         else if (rb_region)
            ack_d = 1'b1;
         else
            ack_d = !fifo_full_i;
      end
   end

   // Push lands on the same edge as the ack
   assign push_o = req_vld & ~ack_q & wb_req_i.we & ~rb_region & ~fifo_full_i;

   assign push_word_o.addr = wb_req_i.adr[SET_AW+1:2];
   assign push_word_o.data = wb_req_i.dat;

   //////////////////////////////
   // Readback mux
   always_comb begin
      case (rb_idx)
         RB_COMPAT: rb_word = COMPAT_NUM;
         RB_LEDS:   rb_word = WB_DW'(rb_words_i.leds);
         RB_BOARD:  rb_word = WB_DW'(rb_words_i.ctl);
         RB_STATUS: rb_word = WB_DW'(rb_words_i.status);
         default:   rb_word = RB_FILL;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= ack_d;
      end
   end

   // Settings region reads as zero
   always_ff @(posedge dsp_clk) begin
      if (ack_d) begin
         rd_dat_q <= rb_region ? rb_word : '0;
      end
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.dat = rd_dat_q;

   // Every ack answers a request seen one cycle earlier
   ack_follows_req: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      $rose(ack_q) |-> $past(req_vld)
   ) else $error("ack without a preceding request");

endmodule

`default_nettype wire

// File: misc_settings_regs.sv
/*
 * Misc settings register bank
 *   clock, SERDES, ADC and PHY reset control lines
 *   LED software value and per-bit LED source select
 *   readback values for the bus slave
 */
`timescale 1ns/100ps
`default_nettype none

module misc_settings_regs (
   input  wire                    dsp_clk,
   input  wire                    por_rst,
   input  core_pkg::set_word_t    head_i,
   input  wire                    empty_i,
   input  wire                    hold_i,
   output logic                   pop_o,
   input  core_pkg::hw_status_t   hw_status_i,
   output core_pkg::board_ctl_t   board_ctl_o,
   output logic [7:0]             leds_o,
   output core_pkg::rb_words_t    rb_words_o
);

   import core_pkg::*;

   logic [7:0] clock_outs;
   logic [7:0] serdes_outs;
   logic [7:0] adc_outs;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;
   logic       phy_reset;

   // Hold freezes the queue so a group of writes lands together
   assign pop_o = ~empty_i & ~hold_i;

   //////////////////////////////
   // Settings registers
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_outs  <= '0;
         serdes_outs <= '0;
         adc_outs    <= '0;
         led_sw      <= '0;
         phy_reset   <= 1'b0;
         led_src     <= LED_SRC_AT_RESET;
      end else if (pop_o) begin
         case (head_i.addr)
            SR_CLK:     clock_outs  <= head_i.data[7:0];
            SR_SER:     serdes_outs <= head_i.data[7:0];
            SR_ADC:     adc_outs    <= head_i.data[7:0];
            SR_LED_SW:  led_sw      <= head_i.data[7:0];
            SR_PHY:     phy_reset   <= head_i.data[0];
            SR_LED_SRC: led_src     <= head_i.data[7:0];
            // Other addresses belong to blocks not present here
            default: ;
         endcase
      end
   end

   //////////////////////////////
   // Control line mapping
   always_comb begin
      board_ctl_o.clock_ready = clock_outs[4];
      board_ctl_o.clk_en      = clock_outs[3:2];
      board_ctl_o.clk_sel     = clock_outs[1:0];
      board_ctl_o.ser_enable  = serdes_outs[3];
      board_ctl_o.ser_prbsen  = serdes_outs[2];
      board_ctl_o.ser_loopen  = serdes_outs[1];
      board_ctl_o.ser_rx_en   = serdes_outs[0];
      board_ctl_o.adc_oe_a    = adc_outs[3];
      board_ctl_o.adc_on_a    = adc_outs[2];
      board_ctl_o.adc_oe_b    = adc_outs[1];
      board_ctl_o.adc_on_b    = adc_outs[0];
      // PHY reset pin is active low
      board_ctl_o.phy_reset_n = ~phy_reset;
   end

   //////////////////////////////
   // LEDs
   // Source bit 1 selects hardware, 0 selects software
   assign led_hw = {3'b000,
                    hw_status_i.run_tx,
                    hw_status_i.run_rx,
                    hw_status_i.clk_status,
                    hw_status_i.serdes_link_up & hw_status_i.good_sync,
                    1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   assign rb_words_o.leds   = leds_o;
   assign rb_words_o.ctl    = board_ctl_o;
   assign rb_words_o.status = hw_status_i;

   // Nothing is applied while the hold is on
   hold_freezes_regs: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      hold_i |=> $stable({board_ctl_o, led_sw, led_src})
   ) else $error("settings applied while hold was high");

endmodule

`default_nettype wire

// File: radio_ctrl_top.sv
/*
 * Top of the radio control core
 *   Wishbone settings slave, settings FIFO and misc register bank
 */
`timescale 1ns/100ps
`default_nettype none

module radio_ctrl_top (
   input  wire                    dsp_clk,
   input  wire                    por_rst,
   input  core_pkg::wb_req_t      wb_req_i,
   output core_pkg::wb_rsp_t      wb_rsp_o,
   input  wire                    settings_hold_i,
   input  core_pkg::hw_status_t   hw_status_i,
   output core_pkg::board_ctl_t   board_ctl_o,
   output logic [7:0]             leds_o
);

   import core_pkg::*;

   logic      fifo_full;
   logic      fifo_empty;
   logic      fifo_push;
   logic      fifo_pop;
   set_word_t push_word;
   set_word_t head_word;
   rb_words_t rb_words;

   //////////////////////////////
   // Bus side
   settings_wb_slave wb_slave (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .wb_req_i     (wb_req_i),
      .wb_rsp_o     (wb_rsp_o),
      .fifo_full_i  (fifo_full),
      .fifo_empty_i (fifo_empty),
      .push_o       (fifo_push),
      .push_word_o  (push_word),
      .rb_words_i   (rb_words)
   );

   // Same-clock queue between bus and registers
   settings_fifo #(
      .DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) set_fifo (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .push_i      (fifo_push),
      .push_word_i (push_word),
      .pop_i       (fifo_pop),
      .head_o      (head_word),
      .full_o      (fifo_full),
      .empty_o     (fifo_empty)
   );

   //////////////////////////////
   // Register side
   misc_settings_regs misc_regs (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .head_i      (head_word),
      .empty_i     (fifo_empty),
      .hold_i      (settings_hold_i),
      .pop_o       (fifo_pop),
      .hw_status_i (hw_status_i),
      .board_ctl_o (board_ctl_o),
      .leds_o      (leds_o),
      .rb_words_o  (rb_words)
   );

endmodule

`default_nettype wire

// File: radio_ctrl_tb.sv
/*
 * Testbench for the radio control core
 *   reads commands from radio_ctrl_tests.txt and drives the Wishbone bus
 *   checks readback words, board control lines and LEDs
 *   watchdog scaled by the length of the tests file
 */
`timescale 1ns/100ps
`default_nettype none

module radio_ctrl_tb;

   import core_pkg::*;

   localparam int CYCLES_PER_LINE = 200;
   localparam int HOLD_WINDOW     = 20;
   localparam     TESTS_FILE      = "radio_ctrl_tests.txt";

   logic       dsp_clk;
   logic       por_rst;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   logic       settings_hold;
   hw_status_t hw_status;
   board_ctl_t board_ctl;
   logic [7:0] leds;

   logic [31:0] rd_data;
   int          line_count;
   int          watchdog_cycles;

   radio_ctrl_top dut_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .wb_req_i        (wb_req),
      .wb_rsp_o        (wb_rsp),
      .settings_hold_i (settings_hold),
      .hw_status_i     (hw_status),
      .board_ctl_o     (board_ctl),
      .leds_o          (leds)
   );

   // 4 ns period
   always #2 dsp_clk = ~dsp_clk;

   //////////////////////////////
   // Reporting
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("** Error at %0.1f ns: %s is 0x%08h, expected 0x%08h",
                             $realtime, name, got, exp));
   endtask

   task automatic need_fields(input int got, input int want, input logic [7:0] cmd);
      if (got != want)
         abort_run($sformatf("Malformed '%c' line in the tests file", cmd));
   endtask

   //////////////////////////////
   // Bus master
   // All tasks start and end 0.5 ns after a rising edge
   task automatic start_request(input logic we, input logic [15:0] adr,
                                input logic [31:0] dat);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.sel = 4'hf;
      wb_req.dat = dat;
   endtask

   // max_cycles of 0 waits until the watchdog
   task automatic wait_ack(input int max_cycles, output logic got);
      int n;
      got = 1'b0;
      n   = 0;
      while (!got && (max_cycles == 0 || n < max_cycles)) begin
         @(posedge dsp_clk);
         #0.5;
         n++;
         if (wb_rsp.ack) begin
            got        = 1'b1;
            rd_data    = wb_rsp.dat;
            wb_req.cyc = 1'b0;
            wb_req.stb = 1'b0;
            // One idle cycle between requests
            @(posedge dsp_clk);
            #0.5;
         end
      end
   endtask

   task automatic bus_write(input logic [15:0] adr, input logic [31:0] dat);
      logic got;
      start_request(1'b1, adr, dat);
      wait_ack(0, got);
   endtask

   // Under hold a read must stall until the hold is dropped
   task automatic bus_read(input logic [15:0] adr, output logic [31:0] dat);
      logic got;
      start_request(1'b0, adr, 32'd0);
      if (settings_hold) begin
         wait_ack(HOLD_WINDOW, got);
         if (got)
            abort_run("Read was acked while queued settings were held");
         settings_hold = 1'b0;
      end
      wait_ack(0, got);
      dat = rd_data;
   endtask

   task automatic queue_under_hold(input int count, input int acks,
                                   input logic [15:0] adr, input logic [31:0] base);
      board_ctl_t  ctl_before;
      logic [31:0] unused;
      logic        got;
      int          acked;
      int          i;
      // Drain first so the queue holds only these writes
      bus_read(16'h0400, unused);
      ctl_before    = board_ctl;
      settings_hold = 1'b1;
      acked         = 0;
      got           = 1'b1;
      for (i = 0; i < count && got; i++) begin
         start_request(1'b1, adr, base + i);
         wait_ack(HOLD_WINDOW, got);
         if (got)
            acked++;
      end
      check_value("write acks under hold", acked, acks);
      check_value("board_ctl_o under hold", {18'd0, ctl_before}, {18'd0, board_ctl});
      settings_hold = 1'b0;
      // Stalled write completes once the queue moves again
      if (!got)
         wait_ack(0, got);
      while (i < count) begin
         bus_write(adr, base + i);
         i++;
      end
   endtask

   //////////////////////////////
   // Watchdog
   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge dsp_clk);
      abort_run("Watchdog expired before the tests file was finished");
   end

   //////////////////////////////
   // Command sequencer
   initial begin
      int               fd;
      int               n;
      logic [7:0]       cmd;
      logic [31:0]      f0;
      logic [31:0]      f1;
      logic [31:0]      f2;
      logic [31:0]      f3;
      logic [31:0]      dat;
      logic [8*128-1:0] line;

      dsp_clk         = 1'b0;
      por_rst         = 1'b1;
      wb_req          = '0;
      settings_hold   = 1'b0;
      hw_status       = '0;
      line_count      = 0;
      watchdog_cycles = 0;

      fd = $fopen(TESTS_FILE, "r");
      if (fd == 0)
         abort_run("Cannot open radio_ctrl_tests.txt");
      while ($fgets(line, fd) > 0)
         line_count++;
      $fclose(fd);
      watchdog_cycles = line_count * CYCLES_PER_LINE + 20;
      fd = $fopen(TESTS_FILE, "r");

      repeat (10) @(posedge dsp_clk);
      #0.5;
      por_rst = 1'b0;

      while ($fscanf(fd, " %c", cmd) == 1) begin
         case (cmd)
            "#": n = $fgets(line, fd);
            "W": begin
               n = $fscanf(fd, "%h %h", f0, f1);
               need_fields(n, 2, cmd);
               bus_write(f0[15:0], f1);
            end
            "R": begin
               n = $fscanf(fd, "%h %h", f0, f1);
               need_fields(n, 2, cmd);
               bus_read(f0[15:0], dat);
               check_value($sformatf("read data at 0x%04h", f0[15:0]), dat, f1);
            end
            "H": begin
               n = $fscanf(fd, "%h", f0);
               need_fields(n, 1, cmd);
               settings_hold = f0[0];
            end
            "S": begin
               n = $fscanf(fd, "%h %h", f0, f1);
               need_fields(n, 2, cmd);
               hw_status = hw_status_t'(f0[4:0]);
               bus_read(16'h0404, dat);
               check_value("leds_o", {24'd0, leds}, f1);
               check_value("readback leds", dat, f1);
            end
            "C": begin
               n = $fscanf(fd, "%h", f0);
               need_fields(n, 1, cmd);
               bus_read(16'h0408, dat);
               check_value("board_ctl_o", {18'd0, board_ctl}, f0);
               check_value("readback board_ctl", dat, f0);
            end
            "Q": begin
               n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
               need_fields(n, 4, cmd);
               queue_under_hold(f0, f1, f2[15:0], f3);
            end
            default: abort_run($sformatf("Unknown command '%c' in the tests file", cmd));
         endcase
      end
      $fclose(fd);

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
core_pkg.sv
settings_fifo.sv
settings_wb_slave.sv
misc_settings_regs.sv
radio_ctrl_top.sv
radio_ctrl_tb.sv

// File: radio_ctrl_tests.txt
# One command per line, fields in hex
# W adr data | R adr expect | H hold | S status leds | C board_ctl | Q count acks adr data
R 0400 000a0000
R 0410 ffffffff
C 0001
S 1f 1e
W 0000 0000001d
W 0004 0000000a
W 0008 00000005
W 0010 00000001
C 3b4a
W 0010 00000000
W 0018 0000000f
W 000c 000000a5
S 1f ae
S 0e ac
S 13 a2
R 040c 00000013
Q 5 4 0000 00000010
C 294b
H 1
W 0004 00000005
R 0408 000028ab
W 0014 ffffffff
W 03fc ffffffff
W 0408 ffffffff
C 28ab
R 0000 00000000
